// ==== hdl/wb2sdr_pkg.sv ====
/*
  Shared widths, queue depths and types of the Wishbone to SDRAM bridge.
  DW must be a multiple of 8. Every SDRAM request is a single beat.
*/

`default_nettype none

package wb2sdr_pkg;

	// --------------------
	// bus widths
	// --------------------

	// word address seen by both buses
	localparam int APP_AW = 26;
	// data path
	localparam int DW = 32;
	// one enable per byte lane
	localparam int BE_W = DW / 8;

	// --------------------
	// queue depths
	// --------------------

	// command queue, shared by reads and writes
	localparam int CMD_DEPTH = 4;
	// write beats may pile up behind a slow controller
	localparam int WRDAT_DEPTH = 8;
	// only one read is ever in flight, so this is generous
	localparam int RDDAT_DEPTH = 4;

	// --------------------
	// vector types
	// --------------------

	typedef logic [APP_AW-1:0] app_addr_t;
	typedef logic [DW-1:0] data_t;
	typedef logic [BE_W-1:0] byte_en_t;

	// {read-not-write, address}
	typedef logic [APP_AW:0] cmd_word_t;
	// {active-low byte enables, data}
	typedef logic [DW+BE_W-1:0] wrbeat_t;

	// pending read tracking
	typedef enum logic [0:0] {
		RD_IDLE = 1'b0,
		RD_WAIT = 1'b1
	} rd_state_e;

endpackage

`default_nettype wire

// ==== hdl/sync_fifo.sv ====
/*
  Synchronous first-word-fall-through queue with an occupancy count.
  Full and empty come from the registered count. A push on full or a pop
  on empty is ignored. DEPTH need not be a power of two.
*/

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4
) (
	input  wire              sdram_clk,
	input  wire              wb_clk_i,
	// write side
	input  wire              push_i,
	input  wire [WIDTH-1:0]  push_data_i,
	output logic             full_o,
	// read side
	input  wire              pop_i,
	output logic [WIDTH-1:0] pop_data_o,
	output logic             empty_o
);

	// pointer needs at least one bit even for a single entry
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	// count runs from 0 up to DEPTH inclusive
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             wr_en;
	logic             rd_en;

	// advance a pointer, wrapping at the last entry
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		logic [PTR_W-1:0] nxt;
		if (ptr == LAST_PTR) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	// --------------------
	// status flags
	// --------------------

	// both flags decode the registered count only
	assign full_o  = (count == FULL_CNT);
	assign empty_o = (count == '0);

	// guarded strobes
	assign wr_en = push_i & ~full_o;
	assign rd_en = pop_i & ~empty_o;

	// --------------------
	// storage
	// --------------------

	always_ff @(posedge sdram_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= push_data_i;
		end
	end

	// oldest entry shown without a read delay
	assign pop_data_o = mem[rd_ptr];

	// --------------------
	// pointers and count
	// --------------------

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_en) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			// push and pop together leave the count alone
			case ({wr_en, rd_en})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wb_req_ctrl.sv ====
/*
  Wishbone request control of the bridge.
  Writes are posted and acknowledged at once when both queues have room.
  Reads are acknowledged with their data, one read in flight at a time.
  The master must hold its request until it sees the acknowledge.
*/

`timescale 1ns/1ps
`default_nettype none

module wb_req_ctrl (
	input  wire  sdram_clk,
	input  wire  wb_clk_i,
	// wishbone request
	input  wire  wb_stb_i,
	input  wire  wb_cyc_i,
	input  wire  wb_we_i,
	// queue status
	input  wire  cmd_full_i,
	input  wire  wrdat_full_i,
	input  wire  rddat_empty_i,
	// decisions
	output logic wb_ack_o,
	output logic cmd_push_o,
	output logic wrdat_push_o,
	output logic rddat_pop_o
);

	import wb2sdr_pkg::*;

	rd_state_e rd_state;
	rd_state_e rd_state_nxt;

	logic wb_req;
	logic wr_req;
	logic rd_req;
	// write accepted this cycle
	logic wr_go;
	// read command queued this cycle
	logic rd_issue;
	// read data handed back this cycle
	logic rd_done;

	// --------------------
	// request decode
	// --------------------

	assign wb_req = wb_stb_i & wb_cyc_i;
	assign wr_req = wb_req & wb_we_i;
	assign rd_req = wb_req & ~wb_we_i;

	// write needs room for both the command and its data beat
	assign wr_go = wr_req & ~cmd_full_i & ~wrdat_full_i;

	// read command goes out only once per wishbone read.
	// the decision looks at the read state alone, never at what the
	// previous cycle did, so a read right behind a write still gets queued
	assign rd_issue = rd_req & (rd_state == RD_IDLE) & ~cmd_full_i;

	// read completes as soon as its word sits in the read queue
	assign rd_done = rd_req & (rd_state == RD_WAIT) & ~rddat_empty_i;

	// --------------------
	// outputs
	// --------------------

	// combinational in the current cycle
	assign wb_ack_o     = wr_go | rd_done;
	assign cmd_push_o   = wr_go | rd_issue;
	assign wrdat_push_o = wr_go;
	assign rddat_pop_o  = rd_done;

	// --------------------
	// read tracking FSM
	// --------------------

	always_comb begin
		rd_state_nxt = rd_state;
		case (rd_state)
			RD_IDLE: begin
				// command pushed, now wait for the word
				if (rd_issue) begin
					rd_state_nxt = RD_WAIT;
				end
			end
			RD_WAIT: begin
				// acked with data, ready for the next read
				if (rd_done) begin
					rd_state_nxt = RD_IDLE;
				end
			end
			default: begin
				rd_state_nxt = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge sdram_clk or posedge wb_clk_i) begin
		if (wb_clk_i) begin
			rd_state <= RD_IDLE;
		end else begin
			rd_state <= rd_state_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/wb2sdr_bridge.sv ====
/*
  Wishbone to SDRAM controller request bridge, single clock domain.
  sdram_clk clocks everything, wb_clk_i is the asynchronous active-high reset.
  Every request is one beat. The controller must not accept or take write
  data from an empty queue, and returns one word per read command.
*/

`timescale 1ns/1ps
`default_nettype none

module wb2sdr_bridge (
	input  wire                    sdram_clk,
	input  wire                    wb_clk_i,
	// --------------------
	// wishbone slave
	// --------------------
	input  wire                    wb_stb_i,
	input  wire                    wb_cyc_i,
	// 1 write, 0 read
	input  wire                    wb_we_i,
	input  wire wb2sdr_pkg::app_addr_t wb_addr_i,
	input  wire wb2sdr_pkg::data_t     wb_dat_i,
	// active-high byte select
	input  wire wb2sdr_pkg::byte_en_t  wb_sel_i,
	output logic                   wb_ack_o,
	output wb2sdr_pkg::data_t      wb_dat_o,
	// --------------------
	// sdram controller
	// --------------------
	// high while a command waits
	output logic                   sdr_req_o,
	output wb2sdr_pkg::app_addr_t  sdr_req_addr_o,
	// 0 write, 1 read
	output logic                   sdr_req_wr_n_o,
	// takes the head command
	input  wire                    sdr_req_ack_i,
	// takes the head write beat
	input  wire                    sdr_wr_next_i,
	// active-low byte enables
	output wb2sdr_pkg::byte_en_t   sdr_wr_en_n_o,
	output wb2sdr_pkg::data_t      sdr_wr_data_o,
	// one returned word per pulse
	input  wire                    sdr_rd_valid_i,
	input  wire wb2sdr_pkg::data_t     sdr_rd_data_i
);

	import wb2sdr_pkg::*;

	// queue status
	logic cmd_full;
	logic cmd_empty;
	logic wrdat_full;
	logic rddat_empty;

	// control decisions
	logic cmd_push;
	logic wrdat_push;
	logic rddat_pop;

	// packed queue words
	cmd_word_t cmd_in;
	cmd_word_t cmd_head;
	wrbeat_t   wrbeat_in;
	wrbeat_t   wrbeat_head;

	// --------------------
	// request control
	// --------------------

	wb_req_ctrl u_req_ctrl (
		.sdram_clk     (sdram_clk),
		.wb_clk_i      (wb_clk_i),
		.wb_stb_i      (wb_stb_i),
		.wb_cyc_i      (wb_cyc_i),
		.wb_we_i       (wb_we_i),
		.cmd_full_i    (cmd_full),
		.wrdat_full_i  (wrdat_full),
		.rddat_empty_i (rddat_empty),
		.wb_ack_o      (wb_ack_o),
		.cmd_push_o    (cmd_push),
		.wrdat_push_o  (wrdat_push),
		.rddat_pop_o   (rddat_pop)
	);

	// --------------------
	// command queue
	// --------------------

	// read-not-write flag on top of the address
	assign cmd_in = {~wb_we_i, wb_addr_i};

	sync_fifo #(
		.WIDTH ($bits(cmd_word_t)),
		.DEPTH (CMD_DEPTH)
	) u_cmdfifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (cmd_push),
		.push_data_i (cmd_in),
		.full_o      (cmd_full),
		.pop_i       (sdr_req_ack_i),
		.pop_data_o  (cmd_head),
		.empty_o     (cmd_empty)
	);

	// request stays up while anything is queued
	assign sdr_req_o = ~cmd_empty;
	assign {sdr_req_wr_n_o, sdr_req_addr_o} = cmd_head;

	// --------------------
	// write data queue
	// --------------------

	// controller expects enables active low
	assign wrbeat_in = {~wb_sel_i, wb_dat_i};

	// empty flag unused, the controller pulls a beat only after a write
	// command it has accepted
	sync_fifo #(
		.WIDTH ($bits(wrbeat_t)),
		.DEPTH (WRDAT_DEPTH)
	) u_wrdatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (wrdat_push),
		.push_data_i (wrbeat_in),
		.full_o      (wrdat_full),
		.pop_i       (sdr_wr_next_i),
		.pop_data_o  (wrbeat_head),
		.empty_o     ()
	);

	assign {sdr_wr_en_n_o, sdr_wr_data_o} = wrbeat_head;

	// --------------------
	// read data queue
	// --------------------

	// one read in flight, so this queue never fills
	sync_fifo #(
		.WIDTH ($bits(data_t)),
		.DEPTH (RDDAT_DEPTH)
	) u_rddatafifo (
		.sdram_clk   (sdram_clk),
		.wb_clk_i    (wb_clk_i),
		.push_i      (sdr_rd_valid_i),
		.push_data_i (sdr_rd_data_i),
		.full_o      (),
		.pop_i       (rddat_pop),
		.pop_data_o  (wb_dat_o),
		.empty_o     (rddat_empty)
	);

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
/*
  Clock and reset source for the bridge testbench.
  Reset is active high from time zero.
  It is released by a non-blocking update on a rising edge.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 40,
	parameter int RST_CYCLES = 16
) (
	output logic clk_o,
	output logic rst_o
);

	// free running, starts low
	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2) clk_o = ~clk_o;
		end
	end

	// hold reset for a fixed number of rising edges
	initial begin
		rst_o = 1'b1;
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== test/tb_wb2sdr.sv ====
/*
  Testbench for the Wishbone to SDRAM bridge. Run it from the project root.
  Operations and expected read data come from test/wb2sdr_testdata.txt.
  The SDRAM model holds 64 words indexed by the low address bits, so the
  data file keeps those bits distinct per location. At most 64 operations.
*/

`timescale 1ns/1ps
`default_nettype none

module tb_wb2sdr;

	import wb2sdr_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 16;
	localparam int MEM_WORDS = 64;
	localparam int MAX_OPS = 64;
	// op, address, data, select, expected
	localparam int FIELDS = 5;
	// watchdog budget per data file line
	localparam int CYCLES_PER_OP = 40;
	localparam logic [31:0] SEED = 32'h0dae0557;

	logic sdram_clk;
	logic wb_clk_i;
	// wishbone master side
	logic wb_stb;
	logic wb_cyc;
	logic wb_we;
	app_addr_t wb_addr;
	data_t wb_dat_wr;
	byte_en_t wb_sel;
	logic wb_ack;
	data_t wb_dat_rd;
	// sdram controller side
	logic sdr_req;
	app_addr_t sdr_req_addr;
	logic sdr_req_wr_n;
	logic sdr_req_ack;
	logic sdr_wr_next;
	byte_en_t sdr_wr_en_n;
	data_t sdr_wr_data;
	logic sdr_rd_valid;
	data_t sdr_rd_data;

	logic [31:0] op_table [FIELDS*MAX_OPS];
	data_t sdr_mem [MEM_WORDS];
	int n_ops;
	bit ops_loaded;
	// requests taken by the model so far
	int acc_idx;
	int stall_cnt;
	int err_cnt;
	int chk_cnt;

	tb_clk_gen #(
		.PERIOD_NS  (CLK_PERIOD),
		.RST_CYCLES (RST_CYCLES)
	) u_clk_gen (
		.clk_o (sdram_clk),
		.rst_o (wb_clk_i)
	);

	wb2sdr_bridge dut0 (
		.sdram_clk      (sdram_clk),
		.wb_clk_i       (wb_clk_i),
		.wb_stb_i       (wb_stb),
		.wb_cyc_i       (wb_cyc),
		.wb_we_i        (wb_we),
		.wb_addr_i      (wb_addr),
		.wb_dat_i       (wb_dat_wr),
		.wb_sel_i       (wb_sel),
		.wb_ack_o       (wb_ack),
		.wb_dat_o       (wb_dat_rd),
		.sdr_req_o      (sdr_req),
		.sdr_req_addr_o (sdr_req_addr),
		.sdr_req_wr_n_o (sdr_req_wr_n),
		.sdr_req_ack_i  (sdr_req_ack),
		.sdr_wr_next_i  (sdr_wr_next),
		.sdr_wr_en_n_o  (sdr_wr_en_n),
		.sdr_wr_data_o  (sdr_wr_data),
		.sdr_rd_valid_i (sdr_rd_valid),
		.sdr_rd_data_i  (sdr_rd_data)
	);

	// --------------------
	// check helpers
	// --------------------

	task automatic check_val(input string name, input logic [31:0] expv,
			input logic [31:0] gotv);
		chk_cnt++;
		assert (gotv === expv)
		else begin
			err_cnt++;
			$display("Error: time %0t %s expected %h got %h", $time, name, expv, gotv);
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		chk_cnt++;
		assert (cond === 1'b1)
		else begin
			err_cnt++;
			$display("at time %0t %s", $time, what);
		end
	endtask

	// one wishbone transfer, returns on the edge that sees the acknowledge
	task automatic run_op(input int idx);
		logic is_wr;
		is_wr = (op_table[idx*FIELDS] != 0);
		wb_stb <= 1'b1;
		wb_cyc <= 1'b1;
		wb_we <= is_wr;
		wb_addr <= app_addr_t'(op_table[idx*FIELDS+1]);
		wb_dat_wr <= data_t'(op_table[idx*FIELDS+2]);
		wb_sel <= byte_en_t'(op_table[idx*FIELDS+3]);
		do begin
			@(posedge sdram_clk);
			// write held off by full queues
			if (is_wr && !wb_ack) begin
				stall_cnt++;
			end
		end while (!wb_ack);
		if (!is_wr) begin
			check_val("wb_dat_o", op_table[idx*FIELDS+4], wb_dat_rd);
		end
	endtask

	// --------------------
	// wishbone master
	// --------------------

	initial begin : master_seq
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
		wb_we <= 1'b0;
		wb_addr <= '0;
		wb_dat_wr <= '0;
		wb_sel <= '0;
		for (int i = 0; i < FIELDS * MAX_OPS; i++) begin
			op_table[i] = '1;
		end
		$readmemh("test/wb2sdr_testdata.txt", op_table);
		// all ones in the op column marks the end of the file
		n_ops = 0;
		while (n_ops < MAX_OPS && op_table[n_ops*FIELDS] !== '1) begin
			n_ops++;
		end
		ops_loaded = 1'b1;
		expect_true(n_ops > 0, "no operations were read from the data file");
		// idle outputs during reset and on the first edge after it
		do begin
			@(posedge sdram_clk);
			check_val("wb_ack_o", 32'd0, 32'(wb_ack));
			check_val("sdr_req_o", 32'd0, 32'(sdr_req));
		end while (wb_clk_i);
		// next operation starts on the acknowledge edge of the last one
		for (int i = 0; i < n_ops; i++) begin
			run_op(i);
		end
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
		// last line is a read, so every command has been taken
		check_val("accepted request count", 32'(n_ops), 32'(acc_idx));
		expect_true(stall_cnt > 0, "the write burst never saw a stalled acknowledge");
		$display("checks %0d errors %0d write stall cycles %0d", chk_cnt, err_cnt, stall_cnt);
		if (err_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// --------------------
	// sdram controller model
	// --------------------

	initial begin : sdram_model
		int dly;
		app_addr_t req_addr;
		logic req_rd;
		data_t wdata;
		byte_en_t wen_n;
		// the model is the only consumer of random delays
		void'($urandom(SEED));
		sdr_req_ack <= 1'b0;
		sdr_wr_next <= 1'b0;
		sdr_rd_valid <= 1'b0;
		sdr_rd_data <= '0;
		// pattern from the whole word index
		for (int i = 0; i < MEM_WORDS; i++) begin
			sdr_mem[i] = 32'hc0de0000 + i * 32'h0101;
		end
		@(negedge wb_clk_i);
		forever begin
			@(posedge sdram_clk);
			if (sdr_req) begin
				dly = $urandom % 6;
				repeat (dly) @(posedge sdram_clk);
				expect_true(sdr_req, "accept due while sdr_req_o is low");
				req_addr = sdr_req_addr;
				req_rd = sdr_req_wr_n;
				// requests must come in data file order
				if (acc_idx < n_ops) begin
					check_val("sdr_req_addr_o",
						32'(app_addr_t'(op_table[acc_idx*FIELDS+1])), 32'(req_addr));
					check_val("sdr_req_wr_n_o",
						32'(op_table[acc_idx*FIELDS] == 0), 32'(req_rd));
				end else begin
					expect_true(1'b0, "more requests arrived than the data file holds");
				end
				acc_idx++;
				sdr_req_ack <= 1'b1;
				@(posedge sdram_clk);
				sdr_req_ack <= 1'b0;
				dly = $urandom % 6;
				repeat (dly) @(posedge sdram_clk);
				if (!req_rd) begin
					// beat of the accepted write sits at the write queue head
					wdata = sdr_wr_data;
					wen_n = sdr_wr_en_n;
					for (int b = 0; b < BE_W; b++) begin
						if (!wen_n[b]) begin
							sdr_mem[req_addr[5:0]][8*b +: 8] = wdata[8*b +: 8];
						end
					end
					sdr_wr_next <= 1'b1;
					@(posedge sdram_clk);
					sdr_wr_next <= 1'b0;
				end else begin
					sdr_rd_data <= sdr_mem[req_addr[5:0]];
					sdr_rd_valid <= 1'b1;
					@(posedge sdram_clk);
					sdr_rd_valid <= 1'b0;
				end
			end
		end
	end

	// --------------------
	// watchdog
	// --------------------

	initial begin : watchdog
		wait (ops_loaded);
		#((n_ops * CYCLES_PER_OP + RST_CYCLES) * CLK_PERIOD);
		$display("timeout: the operations did not complete in time, %0d requests taken", acc_idx);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/wb2sdr_testdata.txt ====
// columns: op (1 write, 0 read), word address, write data, byte select, expected read data
// write lines leave the last column at zero, read lines leave data and select at zero
1 01234401 11111111 f 00000000
1 01234402 22222222 f 00000000
0 01234401 00000000 0 11111111
0 01234402 00000000 0 22222222
1 01234403 aabbccdd 5 00000000
0 01234403 00000000 0 c0bb03dd
1 01234401 99887766 a 00000000
0 01234401 00000000 0 99117711
0 01234410 00000000 0 c0de1010
1 01234404 01234567 f 00000000
0 01234404 00000000 0 01234567
1 01234420 7e000020 f 00000000
1 01234421 7e000021 f 00000000
1 01234422 7e000022 f 00000000
1 01234423 7e000023 f 00000000
1 01234424 7e000024 f 00000000
1 01234425 7e000025 f 00000000
1 01234426 7e000026 f 00000000
1 01234427 7e000027 3 00000000
1 01234428 7e000028 f 00000000
1 01234429 7e000029 f 00000000
0 01234420 00000000 0 7e000020
0 01234421 00000000 0 7e000021
0 01234422 00000000 0 7e000022
0 01234423 00000000 0 7e000023
0 01234424 00000000 0 7e000024
0 01234425 00000000 0 7e000025
0 01234426 00000000 0 7e000026
0 01234427 00000000 0 c0de0027
0 01234428 00000000 0 7e000028
0 01234429 00000000 0 7e000029

// ==== sources.f ====
hdl/wb2sdr_pkg.sv
hdl/sync_fifo.sv
hdl/wb_req_ctrl.sv
hdl/wb2sdr_bridge.sv
test/tb_clk_gen.sv
test/tb_wb2sdr.sv

// ==== Bender.yml ====
package:
  name: wb2sdr_bridge

sources:
  # synthesizable bridge, package first
  - files:
      - hdl/wb2sdr_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/wb_req_ctrl.sv
      - hdl/wb2sdr_bridge.sv
  # simulation only
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_wb2sdr.sv
